// File: zynq_bridge_pkg.sv
package zynq_bridge_pkg;

   // the PS general-purpose port drops the top address bit
   localparam int PS_ADDR_W = 31;

   // core physical addresses are one 32-bit word
   localparam int CORE_ADDR_W = 32;

   // inbound map as seen on the PS port
   //   0x0000_0000 .. 0x2000_0000 maps to core cached DRAM (xor 0x8000_0000)
   //   above 0x2000_0000 maps to core local space (xor 0x2000_0000)
   // the threshold itself still goes to DRAM because the compare is strict
   localparam logic [CORE_ADDR_W-1:0] PS_LOCAL_THRESHOLD = 32'h2000_0000;
   localparam logic [CORE_ADDR_W-1:0] PS_LOCAL_OFFSET    = 32'h2000_0000;
   localparam logic [CORE_ADDR_W-1:0] PS_DRAM_OFFSET     = 32'h8000_0000;

   // outbound rebasing subtracts the core DRAM base before adding the
   // software base, and only the first 256 MB of cached DRAM is backed
   localparam logic [CORE_ADDR_W-1:0] DRAM_BASE_ADDR   = 32'h8000_0000;
   localparam logic [CORE_ADDR_W-1:0] DRAM_WINDOW_SIZE = 32'h1000_0000;

   // APB register block
   localparam int APB_ADDR_W = 4;
   localparam int APB_DATA_W = 32;

   // byte offsets of the three registers
   // any other offset is unmapped
   localparam logic [APB_ADDR_W-1:0] CSR_DRAM_BASE   = 4'h0;
   // writing either counter offset clears that counter whatever the data
   localparam logic [APB_ADDR_W-1:0] CSR_LOCAL_COUNT = 4'h4;
   localparam logic [APB_ADDR_W-1:0] CSR_ERR_COUNT   = 4'h8;

   // a core address read as either a DRAM address or a local address
   // region bit 0 means local space and 1 means cached DRAM
   typedef union packed
   {
      struct packed
      {
         logic        region;
         logic [30:0] offset;
      } dram_view;

      // local layout is 7b tile, 4b device and a 1 MB device window
      struct packed
      {
         logic        region;
         logic [6:0]  tile;
         logic [3:0]  dev;
         logic [19:0] dev_offset;
      } local_view;
   } core_addr_u;

endpackage

// File: bridge_csr.sv
module bridge_csr
(
   input  logic                                    aclk_i,
   input  logic                                    rst_n_i,
   input  logic                                    psel_i,
   input  logic                                    penable_i,
   input  logic                                    pwrite_i,
   input  logic [zynq_bridge_pkg::APB_ADDR_W-1:0]  paddr_i,
   input  logic [zynq_bridge_pkg::APB_DATA_W-1:0]  pwdata_i,
   input  logic                                    local_hit_i,
   input  logic                                    range_err_i,
   output logic [zynq_bridge_pkg::APB_DATA_W-1:0]  prdata_o,
   output logic                                    pready_o,
   output logic                                    pslverr_o,
   output logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] dram_base_o
);
   import zynq_bridge_pkg::*;

   // counter slots, index 0 counts local hits and index 1 range errors
   localparam int N_CNT = 2;

   logic                              apb_access;
   logic                              apb_write;
   logic                              apb_read;
   logic                              hit_base;
   logic                              hit_local;
   logic                              hit_err;
   logic                              mapped;
   logic [N_CNT-1:0]                  cnt_event;
   logic [N_CNT-1:0]                  cnt_clear;
   logic [CORE_ADDR_W-1:0]            dram_base_q;
   logic [N_CNT-1:0][APB_DATA_W-1:0]  count_q;

   // the access phase is the only cycle that matters since pready is
   // tied high and every transfer finishes there
   assign apb_access = psel_i & penable_i;
   assign apb_write  = apb_access & pwrite_i;
   assign apb_read   = apb_access & ~pwrite_i;

   // offsets are matched exactly, so unaligned addresses count as unmapped
   assign hit_base  = (paddr_i == CSR_DRAM_BASE);
   assign hit_local = (paddr_i == CSR_LOCAL_COUNT);
   assign hit_err   = (paddr_i == CSR_ERR_COUNT);
   assign mapped    = hit_base | hit_local | hit_err;

   assign pready_o  = 1'b1;
   assign pslverr_o = apb_access & ~mapped;

   // DRAM base register
   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         dram_base_q <= '0;
      end
      else if (apb_write && hit_base)
      begin
         dram_base_q <= pwdata_i;
      end
   end

   assign dram_base_o = dram_base_q;

   assign cnt_event = {range_err_i, local_hit_i};
   assign cnt_clear = {apb_write & hit_err, apb_write & hit_local};

   // both counters wrap at 32 bits, and a clear in the same cycle as an
   // event drops that event
   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         count_q <= '0;
      end
      else
      begin
         for (int i = 0; i < N_CNT; i++)
         begin
            if (cnt_clear[i])
            begin
               count_q[i] <= '0;
            end
            else if (cnt_event[i])
            begin
               count_q[i] <= count_q[i] + 1'b1;
            end
         end
      end
   end

   // read data only shows up during a read access phase
   always_comb
   begin
      prdata_o = '0;
      if (apb_read)
      begin
         case (1'b1)
            hit_base:  prdata_o = dram_base_q;
            hit_local: prdata_o = count_q[0];
            hit_err:   prdata_o = count_q[1];
            default:   prdata_o = '0;
         endcase
      end
   end

endmodule

// File: ps_addr_translate.sv
module ps_addr_translate
(
   input  logic                                    aclk_i,
   input  logic                                    rst_n_i,
   input  logic                                    ps_valid_i,
   input  logic [zynq_bridge_pkg::PS_ADDR_W-1:0]   ps_addr_i,
   input  logic                                    core_ready_i,
   output logic                                    ps_ready_o,
   output logic                                    core_valid_o,
   output logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] core_addr_o,
   output logic                                    core_local_o,
   output logic [6:0]                              core_tile_o,
   output logic [3:0]                              core_dev_o,
   output logic                                    local_hit_o
);
   import zynq_bridge_pkg::*;

   logic [CORE_ADDR_W-1:0] xor_mask;
   core_addr_u             addr_next;
   core_addr_u             addr_q;
   logic                   valid_q;
   logic                   accept;

   // PS 0x2000_0001 and up lands in local space, the rest in cached DRAM
   always_comb
   begin
      if ({1'b0, ps_addr_i} > PS_LOCAL_THRESHOLD)
      begin
         xor_mask = PS_LOCAL_OFFSET;
      end
      else
      begin
         xor_mask = PS_DRAM_OFFSET;
      end

      // the dropped top PS bit is zero, so the mask alone sets the region
      addr_next.dram_view.region = xor_mask[CORE_ADDR_W-1];
      addr_next.dram_view.offset = ps_addr_i ^ xor_mask[PS_ADDR_W-1:0];
   end

   // single slot, free when empty or drained in this same cycle
   assign ps_ready_o = ~valid_q | core_ready_i;
   assign accept     = ps_valid_i & ps_ready_o;

   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         valid_q <= 1'b0;
      end
      else if (accept)
      begin
         valid_q <= 1'b1;
      end
      else if (core_ready_i)
      begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         addr_q <= addr_next;
      end
   end

   assign core_valid_o = valid_q;
   assign core_addr_o  = addr_q;
   assign core_local_o = ~addr_q.local_view.region;
   assign core_tile_o  = addr_q.local_view.tile;
   assign core_dev_o   = addr_q.local_view.dev;

   // one pulse per local address actually handed to the core
   assign local_hit_o = valid_q & core_ready_i & core_local_o;

endmodule

// File: dram_rebase.sv
module dram_rebase
(
   input  logic                                    aclk_i,
   input  logic                                    rst_n_i,
   input  logic                                    mem_valid_i,
   input  logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] mem_addr_i,
   input  logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] dram_base_i,
   input  logic                                    dram_ready_i,
   output logic                                    mem_ready_o,
   output logic                                    dram_valid_o,
   output logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] dram_addr_o,
   output logic                                    dram_err_o,
   output logic                                    range_err_o
);
   import zynq_bridge_pkg::*;

   logic [CORE_ADDR_W-1:0] dram_offset;
   logic [CORE_ADDR_W-1:0] addr_next;
   logic                   out_of_window;
   logic [CORE_ADDR_W-1:0] addr_q;
   logic                   err_q;
   logic                   valid_q;
   logic                   accept;

   // offset into cached DRAM, wrapping below the base
   assign dram_offset = mem_addr_i - DRAM_BASE_ADDR;

   // addresses below the base wrap to huge offsets, so one unsigned
   // compare covers both ends of the window
   assign out_of_window = (dram_offset >= DRAM_WINDOW_SIZE);

   // flagged requests still go out with the same arithmetic
   assign addr_next = dram_offset + dram_base_i;

   assign mem_ready_o = ~valid_q | dram_ready_i;
   assign accept      = mem_valid_i & mem_ready_o;

   always_ff @(posedge aclk_i)
   begin
      if (!rst_n_i)
      begin
         valid_q <= 1'b0;
      end
      else if (accept)
      begin
         valid_q <= 1'b1;
      end
      else if (dram_ready_i)
      begin
         valid_q <= 1'b0;
      end
   end

   // the base is captured with the request, later CSR writes leave it alone
   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         addr_q <= addr_next;
         err_q  <= out_of_window;
      end
   end

   assign dram_valid_o = valid_q;
   assign dram_addr_o  = addr_q;
   assign dram_err_o   = err_q;
   assign range_err_o  = valid_q & dram_ready_i & err_q;

endmodule

// File: zynq_bridge_top.sv
module zynq_bridge_top
(
   input  logic                                   aclk_i,
   input  logic                                   rst_n_i,

   // APB register access
   input  logic                                   psel_i,
   input  logic                                   penable_i,
   input  logic                                   pwrite_i,
   input  logic [zynq_bridge_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [zynq_bridge_pkg::APB_DATA_W-1:0] pwdata_i,
   output logic [zynq_bridge_pkg::APB_DATA_W-1:0] prdata_o,
   output logic                                   pready_o,
   output logic                                   pslverr_o,

   // inbound stream from the PS port into the core
   input  logic                                   ps_valid_i,
   input  logic [zynq_bridge_pkg::PS_ADDR_W-1:0]  ps_addr_i,
   output logic                                   ps_ready_o,
   output logic                                   core_valid_o,
   output logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] core_addr_o,
   output logic                                   core_local_o,
   output logic [6:0]                             core_tile_o,
   output logic [3:0]                             core_dev_o,
   input  logic                                   core_ready_i,

   // outbound stream from core DRAM requests to PS DRAM
   input  logic                                   mem_valid_i,
   input  logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] mem_addr_i,
   output logic                                   mem_ready_o,
   output logic                                   dram_valid_o,
   output logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] dram_addr_o,
   output logic                                   dram_err_o,
   input  logic                                   dram_ready_i
);
   import zynq_bridge_pkg::*;

   logic [CORE_ADDR_W-1:0] dram_base;
   logic                   local_hit;
   logic                   range_err;

   bridge_csr u_csr
   (
      .aclk_i      (aclk_i),
      .rst_n_i     (rst_n_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .local_hit_i (local_hit),
      .range_err_i (range_err),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .dram_base_o (dram_base)
   );

   ps_addr_translate u_translate
   (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .ps_valid_i   (ps_valid_i),
      .ps_addr_i    (ps_addr_i),
      .core_ready_i (core_ready_i),
      .ps_ready_o   (ps_ready_o),
      .core_valid_o (core_valid_o),
      .core_addr_o  (core_addr_o),
      .core_local_o (core_local_o),
      .core_tile_o  (core_tile_o),
      .core_dev_o   (core_dev_o),
      .local_hit_o  (local_hit)
   );

   dram_rebase u_rebase
   (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .mem_valid_i  (mem_valid_i),
      .mem_addr_i   (mem_addr_i),
      .dram_base_i  (dram_base),
      .dram_ready_i (dram_ready_i),
      .mem_ready_o  (mem_ready_o),
      .dram_valid_o (dram_valid_o),
      .dram_addr_o  (dram_addr_o),
      .dram_err_o   (dram_err_o),
      .range_err_o  (range_err)
   );

endmodule

// File: zynq_bridge_asserts.sv
module zynq_bridge_asserts
(
   input logic                                    aclk_i,
   input logic                                    rst_n_i,
   input logic                                    pready_i,
   input logic                                    core_valid_i,
   input logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] core_addr_i,
   input logic                                    core_ready_i,
   input logic                                    dram_valid_i,
   input logic [zynq_bridge_pkg::CORE_ADDR_W-1:0] dram_addr_i,
   input logic                                    dram_err_i,
   input logic                                    dram_ready_i
);

   // a stalled output keeps its valid and its data until it is taken
   core_hold: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      core_valid_i && !core_ready_i |=> core_valid_i && $stable(core_addr_i))
      else $error("core output changed while stalled");

   dram_hold: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      dram_valid_i && !dram_ready_i |=> dram_valid_i && $stable(dram_addr_i)
         && $stable(dram_err_i))
      else $error("dram output changed while stalled");

   pready_high: assert property (@(posedge aclk_i) disable iff (!rst_n_i) pready_i)
      else $error("pready dropped");

   // reset is synchronous, so the outputs clear one edge later
   reset_idle: assert property (@(posedge aclk_i) !rst_n_i |=> !core_valid_i && !dram_valid_i)
      else $error("valid output high after a reset edge");

endmodule

bind zynq_bridge_top zynq_bridge_asserts u_asserts
(
   .aclk_i       (aclk_i),
   .rst_n_i      (rst_n_i),
   .pready_i     (pready_o),
   .core_valid_i (core_valid_o),
   .core_addr_i  (core_addr_o),
   .core_ready_i (core_ready_i),
   .dram_valid_i (dram_valid_o),
   .dram_addr_i  (dram_addr_o),
   .dram_err_i   (dram_err_o),
   .dram_ready_i (dram_ready_i)
);

// File: tb_zynq_bridge.sv
module tb_zynq_bridge;
   import zynq_bridge_pkg::*;

   localparam int N_ITEMS    = 200;
   // twice the cycle budgets of the reset, APB, inbound, outbound and counter tests
   localparam int MAX_CYCLES = 2 * (40 + 200 + 1200 + 1600 + 60);

   logic                   aclk_i;
   logic                   rst_n_i;
   logic                   psel_i;
   logic                   penable_i;
   logic                   pwrite_i;
   logic [APB_ADDR_W-1:0]  paddr_i;
   logic [APB_DATA_W-1:0]  pwdata_i;
   logic [APB_DATA_W-1:0]  prdata_o;
   logic                   pready_o;
   logic                   pslverr_o;
   logic                   ps_valid_i;
   logic [PS_ADDR_W-1:0]   ps_addr_i;
   logic                   ps_ready_o;
   logic                   core_valid_o;
   logic [CORE_ADDR_W-1:0] core_addr_o;
   logic                   core_local_o;
   logic [6:0]             core_tile_o;
   logic [3:0]             core_dev_o;
   logic                   core_ready_i;
   logic                   mem_valid_i;
   logic [CORE_ADDR_W-1:0] mem_addr_i;
   logic                   mem_ready_o;
   logic                   dram_valid_o;
   logic [CORE_ADDR_W-1:0] dram_addr_o;
   logic                   dram_err_o;
   logic                   dram_ready_i;

   logic [31:0]            lfsr;
   logic [CORE_ADDR_W-1:0] exp_core_q[$];
   logic [CORE_ADDR_W:0]   exp_dram_q[$];
   logic [CORE_ADDR_W-1:0] model_base;
   logic [APB_DATA_W-1:0]  model_local;
   logic [APB_DATA_W-1:0]  model_err;
   logic                   ps_fire;
   logic                   mem_fire;
   int                     in_sent;
   int                     out_sent;
   int                     n_checks;
   int                     err_count;
   int                     test_errs;
   int                     cycle_count = 0;

   zynq_bridge_top u_zynq_bridge_top
   (
      .*
   );

   initial aclk_i = 1'b0;
   always #50 aclk_i = ~aclk_i;

   // Galois LFSR for x^32 + x^22 + x^2 + x + 1 that steps once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      end
      return v;
   endfunction

   // picks the threshold itself, a value just above it, the DRAM range or anywhere
   function automatic logic [PS_ADDR_W-1:0] rand_ps_addr();
      logic [1:0] kind;
      kind = 2'(rand_bits(2));
      case (kind)
         2'd0:    return PS_ADDR_W'(PS_LOCAL_THRESHOLD);
         2'd1:    return PS_ADDR_W'(PS_LOCAL_THRESHOLD + 1 + rand_bits(3));
         2'd2:    return PS_ADDR_W'(rand_bits(29));
         default: return PS_ADDR_W'(rand_bits(PS_ADDR_W));
      endcase
   endfunction

   // half the requests land inside the 256 MB window
   function automatic logic [CORE_ADDR_W-1:0] rand_mem_addr();
      if (rand_bits(1) == 32'd1)
      begin
         return DRAM_BASE_ADDR + rand_bits(28);
      end
      return rand_bits(CORE_ADDR_W);
   endfunction

   function automatic logic [CORE_ADDR_W-1:0] model_translate(input logic [PS_ADDR_W-1:0] a);
      logic [CORE_ADDR_W-1:0] z;
      z = {1'b0, a};
      return (z > PS_LOCAL_THRESHOLD) ? (z ^ PS_LOCAL_OFFSET) : (z ^ PS_DRAM_OFFSET);
   endfunction

   // the top bit carries the out of window flag
   function automatic logic [CORE_ADDR_W:0] model_rebase(input logic [CORE_ADDR_W-1:0] a);
      logic in_window;
      in_window = (a >= DRAM_BASE_ADDR) && (a < DRAM_BASE_ADDR + DRAM_WINDOW_SIZE);
      return {!in_window, a - DRAM_BASE_ADDR + model_base};
   endfunction

   function automatic void check_val(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         err_count++;
      end
   endfunction

   task automatic end_test(input string name);
      $display("test %-20s finished with %0d errors", name, err_count - test_errs);
      test_errs = err_count;
   endtask

   // handshakes are sampled mid-cycle and complete on the next rising edge
   always @(negedge aclk_i)
   begin
      logic [CORE_ADDR_W-1:0] exp_core;
      logic [CORE_ADDR_W:0]   exp_dram;
      ps_fire  = ps_valid_i & ps_ready_o;
      mem_fire = mem_valid_i & mem_ready_o;
      if (core_valid_o && core_ready_i)
      begin
         assert (exp_core_q.size() > 0)
         else
         begin
            $display("core side took an address that was never sent, at %0t", $time);
            err_count++;
         end
         if (exp_core_q.size() > 0)
         begin
            exp_core = exp_core_q.pop_front();
            check_val("core_addr_o", core_addr_o, exp_core);
            check_val("core_local_o", core_local_o, !exp_core[CORE_ADDR_W-1]);
            check_val("core_tile_o", core_tile_o, exp_core[30:24]);
            check_val("core_dev_o", core_dev_o, exp_core[23:20]);
            if (!exp_core[CORE_ADDR_W-1])
            begin
               model_local++;
            end
         end
      end
      if (dram_valid_o && dram_ready_i)
      begin
         assert (exp_dram_q.size() > 0)
         else
         begin
            $display("memory side took an address that was never sent, at %0t", $time);
            err_count++;
         end
         if (exp_dram_q.size() > 0)
         begin
            exp_dram = exp_dram_q.pop_front();
            check_val("dram_addr_o", dram_addr_o, exp_dram[CORE_ADDR_W-1:0]);
            check_val("dram_err_o", dram_err_o, exp_dram[CORE_ADDR_W]);
            if (exp_dram[CORE_ADDR_W])
            begin
               model_err++;
            end
         end
      end
      if (ps_fire)
      begin
         exp_core_q.push_back(model_translate(ps_addr_i));
         in_sent++;
      end
      if (mem_fire)
      begin
         exp_dram_q.push_back(model_rebase(mem_addr_i));
         out_sent++;
      end
   end

   task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] wdata,
                             output logic [APB_DATA_W-1:0] rdata, output logic err);
      @(posedge aclk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= wr;
      paddr_i   <= addr;
      pwdata_i  <= wdata;
      @(posedge aclk_i);
      penable_i <= 1'b1;
      // pready is always high, so the access phase lasts one cycle
      @(negedge aclk_i);
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge aclk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      if (wr)
      begin
         case (addr)
            CSR_DRAM_BASE:   model_base = wdata;
            CSR_LOCAL_COUNT: model_local = '0;
            CSR_ERR_COUNT:   model_err = '0;
            default:         ;
         endcase
      end
   endtask

   task automatic read_check(input string name, input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] exp);
      logic [APB_DATA_W-1:0] rdata;
      logic                  err;
      apb_access(1'b0, addr, '0, rdata, err);
      check_val(name, rdata, exp);
      check_val("pslverr_o", err, 0);
   endtask

   task automatic write_check(input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] data, input logic exp_err);
      logic [APB_DATA_W-1:0] rdata;
      logic                  err;
      apb_access(1'b1, addr, data, rdata, err);
      check_val("pslverr_o", err, exp_err);
   endtask

   task automatic run_inbound();
      while (in_sent < N_ITEMS)
      begin
         @(posedge aclk_i);
         core_ready_i <= (rand_bits(2) != 0);
         // a new address is offered only once the previous one was taken
         if (!ps_valid_i || ps_fire)
         begin
            if (in_sent < N_ITEMS && rand_bits(2) != 0)
            begin
               ps_valid_i <= 1'b1;
               ps_addr_i  <= rand_ps_addr();
            end
            else
            begin
               ps_valid_i <= 1'b0;
            end
         end
      end
      core_ready_i <= 1'b1;
      while (exp_core_q.size() != 0)
      begin
         @(negedge aclk_i);
      end
   endtask

   task automatic run_outbound();
      int                    apb_step;
      logic [APB_DATA_W-1:0] new_base;
      apb_step = 0;
      new_base = '0;
      while (out_sent < N_ITEMS || apb_step != 0)
      begin
         @(posedge aclk_i);
         dram_ready_i <= (rand_bits(2) != 0);
         if (!mem_valid_i || mem_fire)
         begin
            if (out_sent < N_ITEMS && rand_bits(2) != 0)
            begin
               mem_valid_i <= 1'b1;
               mem_addr_i  <= rand_mem_addr();
            end
            else
            begin
               mem_valid_i <= 1'b0;
            end
         end
         // base rewrites run as an APB write beside the stream
         case (apb_step)
            0:
            begin
               if (out_sent < N_ITEMS && rand_bits(4) == 0)
               begin
                  new_base = rand_bits(32);
                  psel_i   <= 1'b1;
                  pwrite_i <= 1'b1;
                  paddr_i  <= CSR_DRAM_BASE;
                  pwdata_i <= new_base;
                  apb_step = 1;
               end
            end
            1:
            begin
               penable_i <= 1'b1;
               apb_step  = 2;
            end
            default:
            begin
               // the new base took effect on this edge
               psel_i     <= 1'b0;
               penable_i  <= 1'b0;
               model_base = new_base;
               apb_step   = 0;
            end
         endcase
      end
      dram_ready_i <= 1'b1;
      while (exp_dram_q.size() != 0)
      begin
         @(negedge aclk_i);
      end
   endtask

   always @(posedge aclk_i)
   begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial
   begin
      logic [APB_DATA_W-1:0] data;
      logic                  err;
      lfsr         = 32'h5cfa;
      model_base   = '0;
      model_local  = '0;
      model_err    = '0;
      ps_fire      = 1'b0;
      mem_fire     = 1'b0;
      in_sent      = 0;
      out_sent     = 0;
      n_checks     = 0;
      err_count    = 0;
      test_errs    = 0;
      rst_n_i      <= 1'b0;
      psel_i       <= 1'b0;
      penable_i    <= 1'b0;
      pwrite_i     <= 1'b0;
      paddr_i      <= '0;
      pwdata_i     <= '0;
      ps_valid_i   <= 1'b0;
      ps_addr_i    <= '0;
      core_ready_i <= 1'b0;
      mem_valid_i  <= 1'b0;
      mem_addr_i   <= '0;
      dram_ready_i <= 1'b0;
      repeat (2) @(posedge aclk_i);
      rst_n_i <= 1'b1;

      @(negedge aclk_i);
      check_val("core_valid_o", core_valid_o, 0);
      check_val("dram_valid_o", dram_valid_o, 0);
      check_val("ps_ready_o", ps_ready_o, 1);
      check_val("mem_ready_o", mem_ready_o, 1);
      read_check("prdata_o(DRAM_BASE)", CSR_DRAM_BASE, 0);
      read_check("prdata_o(LOCAL_COUNT)", CSR_LOCAL_COUNT, 0);
      read_check("prdata_o(ERR_COUNT)", CSR_ERR_COUNT, 0);
      end_test("reset state");

      for (int i = 0; i < 8; i++)
      begin
         data = rand_bits(32);
         write_check(CSR_DRAM_BASE, data, 1'b0);
         read_check("prdata_o(DRAM_BASE)", CSR_DRAM_BASE, data);
      end
      for (int a = 12; a < 16; a++)
      begin
         write_check(4'(a), rand_bits(32), 1'b1);
         apb_access(1'b0, 4'(a), '0, data, err);
         check_val("pslverr_o", err, 1);
      end
      read_check("prdata_o(DRAM_BASE)", CSR_DRAM_BASE, model_base);
      end_test("APB access");

      run_inbound();
      end_test("inbound translation");
      run_outbound();
      end_test("outbound rebasing");

      // an unmapped write while both counters hold events must leave them alone
      write_check(4'hc, rand_bits(32), 1'b1);
      read_check("prdata_o(LOCAL_COUNT)", CSR_LOCAL_COUNT, model_local);
      read_check("prdata_o(ERR_COUNT)", CSR_ERR_COUNT, model_err);
      write_check(CSR_LOCAL_COUNT, rand_bits(32), 1'b0);
      write_check(CSR_ERR_COUNT, rand_bits(32), 1'b0);
      read_check("prdata_o(LOCAL_COUNT)", CSR_LOCAL_COUNT, 0);
      read_check("prdata_o(ERR_COUNT)", CSR_ERR_COUNT, 0);
      end_test("event counters");

      $display("summary: %0d checks, %0d errors", n_checks, err_count);
      if (err_count == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: zynq_bridge_top.f
zynq_bridge_pkg.sv
bridge_csr.sv
ps_addr_translate.sv
dram_rebase.sv
zynq_bridge_top.sv
zynq_bridge_asserts.sv
tb_zynq_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_zynq_bridge
FILELIST  ?= zynq_bridge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
